// ==== hdl/lcd_settings.svh ====
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// clock cycles in one microsecond
`define LCD_CLK_PER_US 3

// panel timing, all in microseconds
`define LCD_POWERUP_US 500
`define LCD_SETUP_US 1
`define LCD_PULSE_US 13
`define LCD_SHORT_WAIT_US 50
`define LCD_LONG_WAIT_US 200

// init steps: enable pulse, then one wait per step
`define LCD_INIT_PULSE_US 10
`define LCD_INIT_WAIT0_US 50
`define LCD_INIT_WAIT1_US 50
`define LCD_INIT_WAIT2_US 200
`define LCD_INIT_WAIT3_US 100

`endif

// ==== hdl/lcd_bus_pkg.sv ====
package lcd_bus_pkg;

	// one-hot instruction classes, highest set bit wins
	typedef struct packed {
		logic set_ddram;
		logic set_cgram;
		logic function_set;
		logic shift;
		logic display_ctrl;
		logic entry_mode;
		logic home;
		logic clear;
	} lcd_instr_t;

	// byte on the bus, as character or as instruction
	typedef union packed {
		logic [7:0] chr;
		lcd_instr_t instr;
	} lcd_byte_u;

	typedef struct packed {
		logic      rs;        // register select, 1 = data
		logic      rw;        // 1 = read
		lcd_byte_u payload;
	} lcd_word_t;

	typedef struct packed {
		logic       e;
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_pins_t;

	typedef struct packed {
		logic lines;       // n bit of function set
		logic font;        // f bit
		logic display_on;
		logic cursor_on;
		logic blink;
		logic increment;   // i/d of entry mode
		logic shift;       // s of entry mode
	} lcd_init_cfg_t;

endpackage

// ==== hdl/lcd_ctrl_pkg.sv ====
package lcd_ctrl_pkg;

	typedef enum logic [1:0] {
		ph_powerup,
		ph_init,
		ph_idle,
		ph_cycle
	} seq_phase_e;

	typedef enum logic [3:0] {
		cmd_clear,
		cmd_home,
		cmd_entry_mode,
		cmd_display_ctrl,
		cmd_shift,
		cmd_function_set,
		cmd_set_cgram,
		cmd_set_ddram,
		cmd_data_access
	} cmd_kind_e;

	typedef struct packed {
		cmd_kind_e  kind;
		logic       long_wait;     // clear and home
		logic       increment;     // i/d bit
		logic       shift_right;   // r/l bit
		logic       cursor_shift;  // s/c bit, set for display shift
		logic [6:0] addr;
	} lcd_cmd_t;

endpackage

// ==== hdl/lcd_cmd_decode.sv ====
module lcd_cmd_decode
	import lcd_bus_pkg::*, lcd_ctrl_pkg::*;
(
	input  lcd_word_t word,
	output lcd_cmd_t  cmd
);

	cmd_kind_e kind;

	always_comb begin
		if (word.rs) begin
			kind = cmd_data_access;
		end else if (word.payload.instr.set_ddram) begin
			kind = cmd_set_ddram;
		end else if (word.payload.instr.set_cgram) begin
			kind = cmd_set_cgram;
		end else if (word.payload.instr.function_set) begin
			kind = cmd_function_set;
		end else if (word.payload.instr.shift) begin
			kind = cmd_shift;
		end else if (word.payload.instr.display_ctrl) begin
			kind = cmd_display_ctrl;
		end else if (word.payload.instr.entry_mode) begin
			kind = cmd_entry_mode;
		end else if (word.payload.instr.home) begin
			kind = cmd_home;
		end else if (word.payload.instr.clear) begin
			kind = cmd_clear;
		end else begin
			// zero byte is no instruction, pick a kind without cursor effect
			kind = cmd_function_set;
		end
	end

	// option bits sit at fixed positions below the class bit
	always_comb begin
		cmd.kind         = kind;
		cmd.long_wait    = (kind == cmd_clear) || (kind == cmd_home);
		cmd.increment    = word.payload.chr[1];    // entry mode i/d
		cmd.shift_right  = word.payload.chr[2];    // shift r/l
		cmd.cursor_shift = word.payload.chr[3];    // shift s/c
		cmd.addr         = word.payload.chr[6:0];  // ddram address
	end

endmodule

// ==== hdl/lcd_bus_sequencer.sv ====
`include "lcd_settings.svh"

module lcd_bus_sequencer
	import lcd_bus_pkg::*, lcd_ctrl_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  lcd_init_cfg_t init_cfg,
	input  logic          lcd_enable,
	input  lcd_word_t     lcd_word,
	input  lcd_cmd_t      cmd,
	output lcd_word_t     issue_word,
	output logic          issue_strobe,
	output lcd_pins_t     pins,
	output logic          busy
);

	localparam int C           = `LCD_CLK_PER_US;
	localparam int POWERUP_CYC = `LCD_POWERUP_US * C;
	localparam int SHORT_CYC   = `LCD_SHORT_WAIT_US * C;
	localparam int LONG_CYC    = `LCD_LONG_WAIT_US * C;
	localparam int STEP0_CYC   = (`LCD_INIT_PULSE_US + `LCD_INIT_WAIT0_US) * C;
	localparam int STEP1_CYC   = (`LCD_INIT_PULSE_US + `LCD_INIT_WAIT1_US) * C;
	localparam int STEP2_CYC   = (`LCD_INIT_PULSE_US + `LCD_INIT_WAIT2_US) * C;
	localparam int STEP3_CYC   = (`LCD_INIT_PULSE_US + `LCD_INIT_WAIT3_US) * C;
	// loose upper bound on any count
	localparam int CNT_W = $clog2(POWERUP_CYC + LONG_CYC + STEP0_CYC + STEP1_CYC
		+ STEP2_CYC + STEP3_CYC);

	localparam logic [CNT_W-1:0] POWERUP_LAST = CNT_W'(POWERUP_CYC - 1);
	localparam logic [CNT_W-1:0] SHORT_LAST   = CNT_W'(SHORT_CYC - 1);
	localparam logic [CNT_W-1:0] LONG_LAST    = CNT_W'(LONG_CYC - 1);
	localparam logic [CNT_W-1:0] INIT_E_END   = CNT_W'(`LCD_INIT_PULSE_US * C);
	localparam logic [CNT_W-1:0] E_START      = CNT_W'(`LCD_SETUP_US * C);
	localparam logic [CNT_W-1:0] E_END = CNT_W'((`LCD_SETUP_US + `LCD_PULSE_US) * C);

	seq_phase_e       phase;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_nxt;
	logic [CNT_W-1:0] wait_last;
	logic [CNT_W-1:0] step_last;
	logic [1:0]       step;   // init step in progress

	function automatic lcd_word_t init_word(input logic [1:0] idx, input lcd_init_cfg_t cfg);
		lcd_word_t w;
		w = '0;
		case (idx)
			2'd0: w.payload.chr = {4'b0011, cfg.lines, cfg.font, 2'b00};
			2'd1: w.payload.chr = {5'b00001, cfg.display_on, cfg.cursor_on, cfg.blink};
			2'd2: w.payload.chr = 8'b0000_0001;
			default: w.payload.chr = {6'b000001, cfg.increment, cfg.shift};
		endcase
		return w;
	endfunction

	function automatic lcd_pins_t bus_pins(input lcd_word_t w, input logic e);
		lcd_pins_t p;
		p.e    = e;
		p.rs   = w.rs;
		p.rw   = w.rw;
		p.data = w.payload.chr;
		return p;
	endfunction

	always_comb begin
		case (step)
			2'd0: step_last = CNT_W'(STEP0_CYC - 1);
			2'd1: step_last = CNT_W'(STEP1_CYC - 1);
			2'd2: step_last = CNT_W'(STEP2_CYC - 1);
			default: step_last = CNT_W'(STEP3_CYC - 1);
		endcase
	end

	assign cnt_nxt   = cnt + 1'b1;
	assign wait_last = cmd.long_wait ? LONG_LAST : SHORT_LAST;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase        <= ph_powerup;
			cnt          <= '0;
			step         <= '0;
			issue_word   <= '0;
			issue_strobe <= 1'b0;
			pins         <= '0;
			busy         <= 1'b1;
		end else begin
			issue_strobe <= 1'b0;
			case (phase)
				ph_powerup: begin
					if (cnt == POWERUP_LAST) begin
						cnt          <= '0;
						step         <= 2'd0;
						phase        <= ph_init;
						issue_word   <= init_word(2'd0, init_cfg);
						issue_strobe <= 1'b1;
						pins         <= bus_pins(init_word(2'd0, init_cfg), 1'b1);
					end else begin
						cnt <= cnt_nxt;
					end
				end
				ph_init: begin
					if (cnt == step_last) begin
						cnt <= '0;
						if (step == 2'd3) begin   // init done
							phase <= ph_idle;
							busy  <= 1'b0;
							pins  <= '0;
						end else begin
							step         <= step + 2'd1;
							issue_word   <= init_word(step + 2'd1, init_cfg);
							issue_strobe <= 1'b1;
							pins <= bus_pins(init_word(step + 2'd1, init_cfg), 1'b1);
						end
					end else begin
						cnt    <= cnt_nxt;
						pins.e <= (cnt_nxt < INIT_E_END);
					end
				end
				ph_idle: begin
					if (lcd_enable) begin   // busy is low here
						cnt          <= '0;
						phase        <= ph_cycle;
						busy         <= 1'b1;
						issue_word   <= lcd_word;
						issue_strobe <= 1'b1;
						pins         <= bus_pins(lcd_word, 1'b0);
					end
				end
				default: begin
					if (cnt == wait_last) begin
						cnt   <= '0;
						phase <= ph_idle;
						busy  <= 1'b0;
						pins  <= '0;
					end else begin
						cnt    <= cnt_nxt;
						pins.e <= (cnt_nxt >= E_START) && (cnt_nxt < E_END);
					end
				end
			endcase
		end
	end

endmodule

// ==== hdl/lcd_cursor_tracker.sv ====
module lcd_cursor_tracker
	import lcd_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       issue_strobe,
	input  lcd_cmd_t   cmd,
	output logic [6:0] cursor_addr
);

	logic       incr;      // entry direction, 1 = increment
	logic [6:0] addr_up;
	logic [6:0] addr_dn;

	// wraps modulo 128
	assign addr_up = cursor_addr + 7'd1;
	assign addr_dn = cursor_addr - 7'd1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cursor_addr <= '0;
			incr        <= 1'b1;
		end else if (issue_strobe) begin
			case (cmd.kind)
				cmd_clear, cmd_home: begin
					cursor_addr <= '0;
				end
				cmd_set_ddram: begin
					cursor_addr <= cmd.addr;
				end
				cmd_entry_mode: begin
					incr <= cmd.increment;
				end
				cmd_shift: begin
					// display shift leaves the counter alone
					if (!cmd.cursor_shift) begin
						cursor_addr <= cmd.shift_right ? addr_up : addr_dn;
					end
				end
				cmd_data_access: begin
					cursor_addr <= incr ? addr_up : addr_dn;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== hdl/lcd_controller.sv ====
module lcd_controller
	import lcd_bus_pkg::*, lcd_ctrl_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  lcd_init_cfg_t init_cfg,
	input  logic          lcd_enable,
	input  lcd_word_t     lcd_word,
	output lcd_pins_t     pins,
	output logic          busy,
	output logic [6:0]    cursor_addr
);

	lcd_word_t issue_word;   // word now on the bus
	logic      issue_strobe;
	lcd_cmd_t  cmd;

	lcd_bus_sequencer u_sequencer (
		.clk          (clk),
		.rst_n        (rst_n),
		.init_cfg     (init_cfg),
		.lcd_enable   (lcd_enable),
		.lcd_word     (lcd_word),
		.cmd          (cmd),
		.issue_word   (issue_word),
		.issue_strobe (issue_strobe),
		.pins         (pins),
		.busy         (busy)
	);

	lcd_cmd_decode u_decode (
		.word (issue_word),
		.cmd  (cmd)
	);

	lcd_cursor_tracker u_cursor (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue_strobe (issue_strobe),
		.cmd          (cmd),
		.cursor_addr  (cursor_addr)
	);

endmodule

// ==== bench/lcd_controller_tb.sv ====
`include "lcd_settings.svh"

module lcd_controller_tb
	import lcd_bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int C          = `LCD_CLK_PER_US;
	localparam int INIT_START = `LCD_POWERUP_US * C;
	localparam int INIT_END   = (`LCD_POWERUP_US + 440) * C;   // busy falls here
	localparam int INIT_E_CYC = `LCD_INIT_PULSE_US * C;
	localparam int B1 = (`LCD_INIT_PULSE_US + `LCD_INIT_WAIT0_US) * C;
	localparam int B2 = B1 + (`LCD_INIT_PULSE_US + `LCD_INIT_WAIT1_US) * C;
	localparam int B3 = B2 + (`LCD_INIT_PULSE_US + `LCD_INIT_WAIT2_US) * C;
	localparam int E_ON      = `LCD_SETUP_US * C;
	localparam int E_OFF     = (`LCD_SETUP_US + `LCD_PULSE_US) * C;
	localparam int SHORT_CYC = `LCD_SHORT_WAIT_US * C;
	localparam int LONG_CYC  = `LCD_LONG_WAIT_US * C;
	localparam int LIMIT     = INIT_END + 40 * (LONG_CYC + 10) + 500;

	logic          clk;
	logic          rst_n;
	lcd_init_cfg_t init_cfg;
	logic          lcd_enable;
	lcd_word_t     lcd_word;
	lcd_pins_t     pins;
	logic          busy;
	logic [6:0]    cursor_addr;

	int          errors = 0;
	int          cycles = 0;
	logic [31:0] lcg_state = 32'hf673;

	// reference model state, one step per rising edge
	int         n_edges;
	logic       host_on;
	int         age;        // cycles since acceptance
	int         wait_cyc;
	lcd_word_t  host_word;
	logic       pend;       // cursor update due next edge
	lcd_word_t  pend_word;
	logic [6:0] m_cursor;
	logic       m_incr;
	logic       exp_busy;
	lcd_pins_t  exp_pins;

	lcd_controller i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.init_cfg    (init_cfg),
		.lcd_enable  (lcd_enable),
		.lcd_word    (lcd_word),
		.pins        (pins),
		.busy        (busy),
		.cursor_addr (cursor_addr)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [7:0] init_byte(input int step, input lcd_init_cfg_t cfg);
		case (step)
			0: return {4'b0011, cfg.lines, cfg.font, 2'b00};
			1: return {5'b00001, cfg.display_on, cfg.cursor_on, cfg.blink};
			2: return 8'h01;
			default: return {6'b000001, cfg.increment, cfg.shift};
		endcase
	endfunction

	function automatic int step_of(input int off);
		if (off < B1) return 0;
		if (off < B2) return 1;
		if (off < B3) return 2;
		return 3;
	endfunction

	function automatic int step_base(input int step);
		case (step)
			0: return 0;
			1: return B1;
			2: return B2;
			default: return B3;
		endcase
	endfunction

	function automatic int wait_for(input lcd_word_t w);
		logic [7:0] b;
		b = w.payload.chr;
		if (!w.rs && (b == 8'h01 || b[7:1] == 7'h01)) return LONG_CYC;   // clear, home
		return SHORT_CYC;
	endfunction

	// returns {direction, address} after the word has executed
	function automatic logic [7:0] cursor_rule(input lcd_word_t w, input logic incr,
		input logic [6:0] addr);
		logic [7:0] b;
		logic [6:0] up;
		logic [6:0] dn;
		b  = w.payload.chr;
		up = addr + 7'd1;
		dn = addr - 7'd1;
		if (w.rs) return {incr, incr ? up : dn};
		casez (b)
			8'b1???_????: return {incr, b[6:0]};
			8'b0001_????: if (!b[3]) return {incr, b[2] ? up : dn};
			8'b0000_01??: return {b[1], addr};
			8'b0000_001?, 8'b0000_0001: return {incr, 7'd0};
			default: ;
		endcase
		return {incr, addr};
	endfunction

	function automatic lcd_word_t rand_cmd();
		logic [31:0] r;
		logic [7:0]  f;
		lcd_word_t   w;
		r = lcg_next();
		f = r[15:8];
		w = '0;
		case (r[23:20])
			4'd6: w.payload.chr = 8'h01;
			4'd7: w.payload.chr = {7'b0000001, f[0]};
			4'd8, 4'd9: w.payload.chr = {6'b000001, f[1:0]};
			4'd10, 4'd11: w.payload.chr = {4'b0001, f[3:0]};
			4'd12, 4'd13: w.payload.chr = {1'b1, f[6:0]};
			4'd14: w.payload.chr = {3'b001, f[4:0]};
			4'd15: w.payload.chr = {2'b01, f[5:0]};
			default: begin   // data access, mostly writes
				w.rs          = 1'b1;
				w.rw          = (f[7:5] == 3'b000);
				w.payload.chr = f;
			end
		endcase
		return w;
	endfunction

	function automatic lcd_word_t rand_junk();
		logic [31:0] r;
		r = lcg_next();
		return r[25:16];
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		errors = errors + 1;
		$display("error %s exp %0h got %0h", name, exp, got);
	endtask

	// one strobe that must be ignored
	task automatic poke_while_busy();
		lcd_enable = 1'b1;
		lcd_word   = rand_junk();
		@(negedge clk);
		lcd_enable = 1'b0;
	endtask

	task automatic send_word(input lcd_word_t w);
		@(negedge clk);
		while (busy) @(negedge clk);
		lcd_enable = 1'b1;
		lcd_word   = w;
		@(negedge clk);
		lcd_enable = 1'b0;
		lcd_word   = rand_junk();   // host word may change once accepted
		repeat (4) @(negedge clk);
		poke_while_busy();
	endtask

	task automatic send_byte(input logic rs, input logic [7:0] b);
		lcd_word_t w;
		w             = '0;
		w.rs          = rs;
		w.payload.chr = b;
		send_word(w);
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			n_edges   <= 0;
			host_on   <= 1'b0;
			age       <= 0;
			wait_cyc  <= 0;
			host_word <= '0;
			pend      <= 1'b0;
			pend_word <= '0;
			m_cursor  <= '0;
			m_incr    <= 1'b1;
		end else begin
			n_edges <= n_edges + 1;
			pend    <= 1'b0;
			if (pend) begin
				{m_incr, m_cursor} <= cursor_rule(pend_word, m_incr, m_cursor);
			end
			if (n_edges + 1 < INIT_END && n_edges + 1 - INIT_START >= 0
				&& step_base(step_of(n_edges + 1 - INIT_START)) == n_edges + 1 - INIT_START) begin
				pend      <= 1'b1;   // init step starts
				pend_word <= {2'b00, init_byte(step_of(n_edges + 1 - INIT_START), init_cfg)};
			end
			if (host_on) begin
				age <= age + 1;
				if (age + 1 == wait_cyc) host_on <= 1'b0;
			end else if (n_edges >= INIT_END && lcd_enable) begin
				host_on   <= 1'b1;
				age       <= 0;
				wait_cyc  <= wait_for(lcd_word);
				host_word <= lcd_word;
				pend      <= 1'b1;
				pend_word <= lcd_word;
			end
		end
	end

	always_comb begin : expect_outputs
		int off;
		off      = n_edges - INIT_START;
		exp_busy = 1'b1;
		exp_pins = '0;
		if (n_edges >= INIT_END) begin
			exp_busy = host_on;
			if (host_on) begin
				exp_pins.e    = (age >= E_ON) && (age < E_OFF);
				exp_pins.rs   = host_word.rs;
				exp_pins.rw   = host_word.rw;
				exp_pins.data = host_word.payload.chr;
			end
		end else if (off >= 0) begin
			exp_pins.e    = (off - step_base(step_of(off))) < INIT_E_CYC;
			exp_pins.data = init_byte(step_of(off), init_cfg);
		end
	end

	chk_busy: assert property (@(posedge clk) disable iff (!rst_n) busy === exp_busy)
		else report_mismatch("busy", $sampled(exp_busy), $sampled(busy));
	chk_e: assert property (@(posedge clk) disable iff (!rst_n) pins.e === exp_pins.e)
		else report_mismatch("pins.e", $sampled(exp_pins.e), $sampled(pins.e));
	chk_rs_rw: assert property (@(posedge clk) disable iff (!rst_n)
		{pins.rs, pins.rw} === {exp_pins.rs, exp_pins.rw})
		else report_mismatch("pins.rs_rw", $sampled({exp_pins.rs, exp_pins.rw}),
			$sampled({pins.rs, pins.rw}));
	chk_data: assert property (@(posedge clk) disable iff (!rst_n) pins.data === exp_pins.data)
		else report_mismatch("pins.data", $sampled(exp_pins.data), $sampled(pins.data));
	chk_cursor: assert property (@(posedge clk) disable iff (!rst_n) cursor_addr === m_cursor)
		else report_mismatch("cursor_addr", $sampled(m_cursor), $sampled(cursor_addr));

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		lcd_enable = 1'b0;
		lcd_word   = '0;
		init_cfg   = 7'b1_0_1_0_1_0_1;   // 2 lines, display on, blink, decrement with shift
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		repeat (100) @(negedge clk);
		poke_while_busy();   // during power-up wait
		repeat (INIT_START + B2) @(negedge clk);
		poke_while_busy();   // during init clear step
		repeat (3) send_byte(1'b1, 8'h42);   // decrement left by init, wraps below 0
		send_byte(1'b0, 8'h06);   // increment
		send_byte(1'b0, 8'hfd);   // near the top of ddram
		repeat (4) send_byte(1'b1, 8'h41);   // wraps past 127
		send_word({1'b1, 1'b1, 8'h00});   // data read steps the counter too
		send_byte(1'b0, 8'h04);   // decrement
		send_byte(1'b1, 8'h42);
		send_byte(1'b0, 8'h02);
		send_byte(1'b0, 8'h01);
		send_byte(1'b0, 8'h14);   // cursor right
		send_byte(1'b0, 8'h1c);   // display shift only
		send_byte(1'b0, 8'h10);   // cursor left
		send_byte(1'b0, 8'h06);
		repeat (22) send_word(rand_cmd());
		@(negedge clk);
		while (busy) @(negedge clk);
		repeat (3) @(negedge clk);
		$display("lcd_controller_tb finished with %0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/lcd_bus_pkg.sv
hdl/lcd_ctrl_pkg.sv
hdl/lcd_cmd_decode.sv
hdl/lcd_bus_sequencer.sv
hdl/lcd_cursor_tracker.sv
hdl/lcd_controller.sv
bench/lcd_controller_tb.sv

// ==== Bender.yml ====
package:
  name: lcd_controller

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lcd_bus_pkg.sv
      - hdl/lcd_ctrl_pkg.sv
      - hdl/lcd_cmd_decode.sv
      - hdl/lcd_bus_sequencer.sv
      - hdl/lcd_cursor_tracker.sv
      - hdl/lcd_controller.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/lcd_controller_tb.sv
